/* apb_imem_port.sv */
// APB slave of the fetch subsystem
// holds the run bit, reads back the fetch PC and turns window writes into
// instruction memory writes while fetching is stopped; all bus errors come from here

`timescale 1ns/1ps

module apb_imem_port #(
   parameter mips_isa_pkg::word_t RESET_PC   = mips_isa_pkg::DEFAULT_RESET_PC,
   parameter int unsigned         IMEM_WORDS = 256
) (
   input  logic                            clk,
   input  logic                            arst_n,
   input  logic                            psel,
   input  logic                            penable,
   input  logic                            pwrite,
   input  fetch_bus_pkg::apb_addr_t        paddr,
   input  mips_isa_pkg::word_t             pwdata,
   output mips_isa_pkg::word_t             prdata,
   output logic                            pready,
   output logic                            pslverr,
   input  mips_isa_pkg::word_t             pc_f,
   output logic                            run,
   output logic                            wr_en,
   output logic [$clog2(IMEM_WORDS)-1:0]   wr_index,
   output mips_isa_pkg::word_t             wr_data
);

   import mips_isa_pkg::*;
   import fetch_bus_pkg::*;

   localparam int IDX_W   = $clog2(IMEM_WORDS);
   localparam int BYTE_SH = $clog2(WORD_BYTES);

   logic      access;     // access phase of a transfer
   apb_addr_t mem_off;    // byte offset into the window
   logic      hit_ctrl;
   logic      hit_pc;
   logic      hit_mem;
   logic      err;
   word_t     ctrl_word;

   assign access   = psel & penable;
   assign mem_off  = paddr - IMEM_BASE;
   assign hit_ctrl = (paddr == REG_CTRL);
   assign hit_pc   = (paddr == REG_PC);
   // word aligned and below the top of memory
   assign hit_mem  = (paddr >= IMEM_BASE) && (mem_off[BYTE_SH-1:0] == '0) &&
                     ((mem_off >> BYTE_SH) < IMEM_WORDS);

   always_comb begin
      err = 1'b0;
      if (!(hit_ctrl || hit_pc || hit_mem))
         err = 1'b1;                     // unmapped
      else if (hit_pc && pwrite)
         err = 1'b1;                     // PC is read only
      else if (hit_mem && !pwrite)
         err = 1'b1;                     // no host reads of memory
      else if (hit_mem && run)
         err = 1'b1;                     // program is locked while fetching
   end

   always_comb begin
      ctrl_word               = '0;
      ctrl_word[CTRL_RUN_BIT] = run;
   end

   // read data only during a good read access and zero otherwise
   assign prdata  = (access && !pwrite && !err) ? (hit_pc ? pc_f : ctrl_word) : '0;
   assign pready  = 1'b1;   // zero wait states
   assign pslverr = access & err;

   assign wr_en    = access & pwrite & hit_mem & ~err;
   assign wr_index = mem_off[BYTE_SH +: IDX_W];
   assign wr_data  = pwdata;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         run <= 1'b0;
      else if (access && pwrite && hit_ctrl)
         run <= pwdata[CTRL_RUN_BIT];   // takes effect on the completing edge
   end

   // memory must never change under a running fetch
   a_no_write_running: assert property (@(posedge clk) disable iff (!arst_n)
      wr_en |-> !run);

   // fetch leaves reset at the same PC the host sees
   a_reset_pc: assert property (@(posedge clk) $rose(arst_n) |-> pc_f == RESET_PC);

endmodule

/* compile.f */
mips_isa_pkg.sv
fetch_bus_pkg.sv
apb_imem_port.sv
instr_mem.sv
pc_select.sv
fetch.sv
fetch_decode_reg.sv
fetch_top.sv
fetch_checker.sv
tb_fetch_top.sv

/* fetch.sv */
// fetch stage core
// program counter with run/stall enable, next-PC select and memory read request;
// the memory word comes back one edge later together with the new PC

`timescale 1ns/1ps

module fetch #(
   parameter mips_isa_pkg::word_t RESET_PC   = mips_isa_pkg::DEFAULT_RESET_PC,
   parameter int unsigned         IMEM_WORDS = 256
) (
   input  logic                            clk,
   input  logic                            arst_n,
   input  logic                            run,
   input  logic                            enable,        // not stall from hazard unit
   input  logic                            jump,
   input  logic                            jump_reg,
   input  logic                            branch,
   input  mips_isa_pkg::word_t             jump_addr,
   input  mips_isa_pkg::word_t             jump_reg_addr,
   input  mips_isa_pkg::word_t             branch_addr,
   output mips_isa_pkg::word_t             instr_f,
   output mips_isa_pkg::word_t             pc_f,
   output mips_isa_pkg::word_t             pc_plus_4_f,
   output logic                            valid_f,
   output logic                            rd_en,
   output logic [$clog2(IMEM_WORDS)-1:0]   rd_index,
   input  mips_isa_pkg::word_t             instr
);

   import mips_isa_pkg::*;

   localparam int IDX_W   = $clog2(IMEM_WORDS);
   localparam int BYTE_SH = $clog2(WORD_BYTES);

   word_t pc_next;
   word_t pc_off;    // next PC relative to the boot address
   logic  advance;

   pc_select u_pc_select (
      .clk           (clk),
      .arst_n        (arst_n),
      .pc_f          (pc_f),
      .jump          (jump),
      .jump_reg      (jump_reg),
      .branch        (branch),
      .jump_addr     (jump_addr),
      .jump_reg_addr (jump_reg_addr),
      .branch_addr   (branch_addr),
      .pc_plus_4     (pc_plus_4_f),
      .pc_next       (pc_next)
   );

   assign advance = run & enable;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         pc_f <= RESET_PC;
      else if (advance)
         pc_f <= pc_next;
   end

   // high from the first advancing edge, drops one edge after run clears
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         valid_f <= 1'b0;
      else if (!run)
         valid_f <= 1'b0;
      else if (enable)
         valid_f <= 1'b1;
   end

   // word index wraps modulo memory size
   assign pc_off   = pc_next - RESET_PC;
   assign rd_index = pc_off[BYTE_SH +: IDX_W];
   assign rd_en    = advance;      // same edge as the PC load
   assign instr_f  = instr;        // already aligned with pc_f

endmodule

/* fetch_bus_pkg.sv */
// host-side register map of the fetch subsystem
// APB address layout, control bit positions and the program-load window

package fetch_bus_pkg;

   localparam int APB_ADDR_W = 16;   // byte address on the host port

   typedef logic [APB_ADDR_W-1:0] apb_addr_t;

   // control register, bit 0 is run, read/write
   localparam apb_addr_t REG_CTRL = 16'h0000;

   // current fetch PC, read only
   localparam apb_addr_t REG_PC = 16'h0004;

   // instruction memory write window
   // word n lives at IMEM_BASE + 4*n
   localparam apb_addr_t IMEM_BASE = 16'h1000;

   localparam int CTRL_RUN_BIT = 0;   // position of run in REG_CTRL

endpackage

/* fetch_checker.sv */
// watches the fetch subsystem ports and compares them with the testbench model
// counts compares, errors and decode beats for the per-test summary

`timescale 1ns/1ps

module fetch_checker (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                psel,
   input  logic                penable,
   input  logic                pwrite,
   input  mips_isa_pkg::word_t prdata,
   input  logic                pslverr,
   input  mips_isa_pkg::word_t pc_f,
   input  logic                valid_d,
   input  mips_isa_pkg::word_t instr_d,
   input  mips_isa_pkg::word_t pc_plus_4_d,
   input  mips_isa_pkg::word_t exp_pc,
   input  logic                exp_valid_d,
   input  mips_isa_pkg::word_t exp_instr_d,
   input  mips_isa_pkg::word_t exp_pc4_d,
   input  logic                exp_err,
   input  mips_isa_pkg::word_t exp_prdata,
   output int                  errors,
   output int                  checks,
   output int                  beats
);

   import mips_isa_pkg::*;

   int bad;    // errors seen on this edge
   int done;   // compares made on this edge

   initial begin
      errors = 0;
      checks = 0;
      beats  = 0;
   end

   task automatic compare(string what, word_t got, word_t exp);
      done++;
      if (got !== exp) begin
         bad++;
         $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   // registered outputs and model state both hold their pre-edge values here
   always @(posedge clk) begin
      bad  = 0;
      done = 0;
      if (arst_n) begin
         compare("pc_f", pc_f, exp_pc);
         compare("valid_d", valid_d, exp_valid_d);
         if (valid_d && exp_valid_d) begin
            compare("instr_d", instr_d, exp_instr_d);
            compare("pc_plus_4_d", pc_plus_4_d, exp_pc4_d);
            beats <= beats + 1;
         end
         if (psel && penable) begin   // access phase
            compare("pslverr", pslverr, exp_err);
            if (!pwrite && !exp_err)
               compare("prdata", prdata, exp_prdata);
         end
      end
      errors <= errors + bad;
      checks <= checks + done;
   end

endmodule

/* fetch_decode_reg.sv */
// IF/ID pipeline register
// loads instruction, PC+4 and valid when enable is high, holds on stall

`timescale 1ns/1ps

module fetch_decode_reg (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                enable,
   input  mips_isa_pkg::word_t instr_f,
   input  mips_isa_pkg::word_t pc_plus_4_f,
   input  logic                valid_f,
   output mips_isa_pkg::word_t instr_d,
   output mips_isa_pkg::word_t pc_plus_4_d,
   output logic                valid_d
);

   import mips_isa_pkg::*;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         instr_d     <= '0;
         pc_plus_4_d <= '0;
         valid_d     <= 1'b0;
      end else if (enable) begin
         instr_d     <= instr_f;
         pc_plus_4_d <= pc_plus_4_f;   // decode uses it for jal and branch targets
         valid_d     <= valid_f;
      end
   end

endmodule

/* fetch_top.sv */
// fetch subsystem top level
// APB host port for program load and run control, fetch stage, instruction
// memory and the IF/ID register; redirects come from decode and execute

`timescale 1ns/1ps

module fetch_top #(
   parameter mips_isa_pkg::word_t RESET_PC   = mips_isa_pkg::DEFAULT_RESET_PC,
   parameter int unsigned         IMEM_WORDS = 256
) (
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic                     psel,
   input  logic                     penable,
   input  logic                     pwrite,
   input  fetch_bus_pkg::apb_addr_t paddr,
   input  mips_isa_pkg::word_t      pwdata,
   output mips_isa_pkg::word_t      prdata,
   output logic                     pready,
   output logic                     pslverr,
   input  logic                     jump,
   input  logic                     jump_reg,
   input  logic                     branch,
   input  mips_isa_pkg::word_t      jump_addr,
   input  mips_isa_pkg::word_t      jump_reg_addr,
   input  mips_isa_pkg::word_t      branch_addr,
   input  logic                     enable,
   output mips_isa_pkg::word_t      instr_d,
   output mips_isa_pkg::word_t      pc_plus_4_d,
   output logic                     valid_d,
   output mips_isa_pkg::word_t      pc_f
);

   import mips_isa_pkg::*;

   localparam int IDX_W = $clog2(IMEM_WORDS);

   logic             run;
   logic             wr_en;         // host program load
   logic [IDX_W-1:0] wr_index;
   word_t            wr_data;
   logic             rd_en;         // fetch read
   logic [IDX_W-1:0] rd_index;
   word_t            instr;
   word_t            instr_f;
   word_t            pc_plus_4_f;
   logic             valid_f;

   apb_imem_port #(
      .RESET_PC   (RESET_PC),
      .IMEM_WORDS (IMEM_WORDS)
   ) u_apb_imem_port (
      .clk      (clk),
      .arst_n   (arst_n),
      .psel     (psel),
      .penable  (penable),
      .pwrite   (pwrite),
      .paddr    (paddr),
      .pwdata   (pwdata),
      .prdata   (prdata),
      .pready   (pready),
      .pslverr  (pslverr),
      .pc_f     (pc_f),
      .run      (run),
      .wr_en    (wr_en),
      .wr_index (wr_index),
      .wr_data  (wr_data)
   );

   instr_mem #(
      .IMEM_WORDS (IMEM_WORDS)
   ) u_instr_mem (
      .clk      (clk),
      .arst_n   (arst_n),
      .wr_en    (wr_en),
      .wr_index (wr_index),
      .wr_data  (wr_data),
      .rd_en    (rd_en),
      .rd_index (rd_index),
      .instr    (instr)
   );

   fetch #(
      .RESET_PC   (RESET_PC),
      .IMEM_WORDS (IMEM_WORDS)
   ) u_fetch (
      .clk           (clk),
      .arst_n        (arst_n),
      .run           (run),
      .enable        (enable),
      .jump          (jump),
      .jump_reg      (jump_reg),
      .branch        (branch),
      .jump_addr     (jump_addr),
      .jump_reg_addr (jump_reg_addr),
      .branch_addr   (branch_addr),
      .instr_f       (instr_f),
      .pc_f          (pc_f),
      .pc_plus_4_f   (pc_plus_4_f),
      .valid_f       (valid_f),
      .rd_en         (rd_en),
      .rd_index      (rd_index),
      .instr         (instr)
   );

   // decode side, same enable as the PC
   fetch_decode_reg u_fetch_decode_reg (
      .clk         (clk),
      .arst_n      (arst_n),
      .enable      (enable),
      .instr_f     (instr_f),
      .pc_plus_4_f (pc_plus_4_f),
      .valid_f     (valid_f),
      .instr_d     (instr_d),
      .pc_plus_4_d (pc_plus_4_d),
      .valid_d     (valid_d)
   );

endmodule

/* instr_mem.sv */
// instruction memory, one word per entry
// host write port from the APB slave, registered fetch read that holds on stall

`timescale 1ns/1ps

module instr_mem #(
   parameter int unsigned IMEM_WORDS = 256
) (
   input  logic                            clk,
   input  logic                            arst_n,
   input  logic                            wr_en,
   input  logic [$clog2(IMEM_WORDS)-1:0]   wr_index,
   input  mips_isa_pkg::word_t             wr_data,
   input  logic                            rd_en,
   input  logic [$clog2(IMEM_WORDS)-1:0]   rd_index,
   output mips_isa_pkg::word_t             instr
);

   import mips_isa_pkg::*;

   word_t mem [IMEM_WORDS];   // program storage

   // host side, one word per completed APB write
   always_ff @(posedge clk) begin
      if (wr_en)
         mem[wr_index] <= wr_data;
   end

   // fetch side
   // rd_index comes from the next PC so the word lines up with the new pc_f
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         instr <= '0;
      else if (rd_en)
         instr <= mem[rd_index];   // held while stalled or stopped
   end

endmodule

/* mips_isa_pkg.sv */
// shared machine-word and instruction-format definitions for the fetch pipeline
// imported by the pipeline modules and by the testbench that builds programs

package mips_isa_pkg;

   // datapath width
   localparam int WORD_W = 32;

   // instructions, PCs and branch/jump targets all travel as one word
   typedef logic [WORD_W-1:0] word_t;

   localparam int WORD_BYTES = 4;   // sequential PC step

   // boot address of the text segment
   localparam word_t DEFAULT_RESET_PC = 32'h0040_0000;

   // primary opcode field, bits 31:26 of every format
   typedef logic [5:0] opcode_t;

   localparam int OPCODE_LSB = 26;   // low bit of opcode in the word
   localparam int JTARGET_W  = 26;   // J-format word-index field

   // J-format opcodes
   localparam opcode_t OPC_J   = 6'h02;
   localparam opcode_t OPC_JAL = 6'h03;

   // R-format register fields
   localparam int RS_LSB = 21;
   localparam int RT_LSB = 16;
   localparam int RD_LSB = 11;

   localparam int REG_IDX_W = 5;   // 32 general registers

endpackage

/* pc_select.sv */
// next-PC logic of the fetch stage
// PC+4 adder and the branch / jump / jump-register priority select

`timescale 1ns/1ps

module pc_select (
   input  logic                clk,
   input  logic                arst_n,
   input  mips_isa_pkg::word_t pc_f,
   input  logic                jump,
   input  logic                jump_reg,
   input  logic                branch,
   input  mips_isa_pkg::word_t jump_addr,
   input  mips_isa_pkg::word_t jump_reg_addr,
   input  mips_isa_pkg::word_t branch_addr,
   output mips_isa_pkg::word_t pc_plus_4,
   output mips_isa_pkg::word_t pc_next
);

   import mips_isa_pkg::*;

   assign pc_plus_4 = pc_f + WORD_BYTES;   // sequential successor

   // branch wins over jump, jump_reg only picks which jump target
   always_comb begin
      pc_next = pc_plus_4;
      if (branch)
         pc_next = branch_addr;
      else if (jump)
         pc_next = jump_reg ? jump_reg_addr : jump_addr;
   end

   // alignment of the PC register holds over time as long as targets are aligned
   a_next_aligned: assert property (@(posedge clk) disable iff (!arst_n)
      (jump_addr[1:0] == 2'b00 && jump_reg_addr[1:0] == 2'b00 &&
       branch_addr[1:0] == 2'b00) |-> pc_next[1:0] == 2'b00);

endmodule

/* tb_fetch_top.sv */
// testbench for the fetch subsystem
// loads a random program over APB, runs it with redirects, stalls and bus errors,
// and keeps a cycle model of the fetch rules that fetch_checker compares against

`timescale 1ns/1ps

module tb_fetch_top;

   import mips_isa_pkg::*;
   import fetch_bus_pkg::*;

   localparam word_t RESET_PC   = DEFAULT_RESET_PC;
   localparam int    IMEM_WORDS = 256;

   logic      clk, arst_n, psel, penable, pwrite, pready, pslverr;
   logic      jump, jump_reg, branch, enable, valid_d;
   apb_addr_t paddr;
   word_t     pwdata, prdata, jump_addr, jump_reg_addr, branch_addr;
   word_t     instr_d, pc_plus_4_d, pc_f;

   word_t model_mem [IMEM_WORDS];   // same words the host loads
   logic  m_run, m_valid_f, m_valid_d, exp_err;
   word_t m_pc, m_next, m_instr_f, m_instr_d, m_pc4_d, exp_prdata;
   int    chk_errors, checks, beats;
   int    tb_fails  = 0;            // timeouts and other non-value failures
   int    n_failed  = 0;
   int    test_base = 0;

   // branch first, then jump with jump_reg picking the register target
   function automatic word_t predict_next_pc(word_t pc, logic br, logic jmp, logic jr,
                                             word_t ja, word_t jra, word_t ba);
      if (br)
         return ba;
      if (jmp)
         return jr ? jra : ja;
      return pc + WORD_BYTES;
   endfunction

   function automatic int pc_index(word_t pc);
      word_t off;
      off = pc - RESET_PC;
      return (off / WORD_BYTES) % IMEM_WORDS;   // wraps over the memory size
   endfunction

   function automatic logic bus_error(apb_addr_t a, logic wr, logic running);
      logic in_win;
      in_win = (a >= IMEM_BASE) && (a < IMEM_BASE + WORD_BYTES * IMEM_WORDS) &&
               (a % WORD_BYTES == 0);
      if (a == REG_CTRL)
         return 1'b0;
      if (a == REG_PC)
         return wr;            // read only
      if (!in_win)
         return 1'b1;          // unmapped
      return !wr || running;   // window is write only and locked while fetching
   endfunction

   function automatic word_t program_word(int n);
      opcode_t op;
      word_t   w;
      op = OPC_J;
      w  = $urandom;
      if (n % 8 == 7)
         w = {op, w[JTARGET_W-1:0]};   // a j instruction now and then
      return w;
   endfunction

   function automatic word_t rand_target();
      return RESET_PC + WORD_BYTES * ($urandom % 32);   // aligned and inside the loaded words
   endfunction

   assign m_next  = predict_next_pc(m_pc, branch, jump, jump_reg, jump_addr,
                                    jump_reg_addr, branch_addr);
   assign exp_err = bus_error(paddr, pwrite, m_run);

   always_comb begin
      exp_prdata = '0;
      if (paddr == REG_PC)
         exp_prdata = m_pc;
      else
         exp_prdata[CTRL_RUN_BIT] = m_run;
   end

   // model of run, PC, fetch word and IF/ID register
   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         m_run     <= 1'b0;
         m_pc      <= RESET_PC;
         m_instr_f <= '0;
         m_valid_f <= 1'b0;
         m_instr_d <= '0;
         m_pc4_d   <= '0;
         m_valid_d <= 1'b0;
      end else begin
         if (psel && penable && pwrite && !exp_err) begin
            if (paddr == REG_CTRL)
               m_run <= pwdata[CTRL_RUN_BIT];
            else
               model_mem[(paddr - IMEM_BASE) / WORD_BYTES] <= pwdata;
         end
         if (m_run && enable) begin
            m_pc      <= m_next;
            m_instr_f <= model_mem[pc_index(m_next)];   // word of the new PC
         end
         if (!m_run)
            m_valid_f <= 1'b0;
         else if (enable)
            m_valid_f <= 1'b1;
         if (enable) begin
            m_instr_d <= m_instr_f;
            m_pc4_d   <= m_pc + WORD_BYTES;
            m_valid_d <= m_valid_f;
         end
      end
   end

   fetch_top #(
      .RESET_PC   (RESET_PC),
      .IMEM_WORDS (IMEM_WORDS)
   ) u_fetch_top (.*);

   fetch_checker u_fetch_checker (
      .clk         (clk),
      .arst_n      (arst_n),
      .psel        (psel),
      .penable     (penable),
      .pwrite      (pwrite),
      .prdata      (prdata),
      .pslverr     (pslverr),
      .pc_f        (pc_f),
      .valid_d     (valid_d),
      .instr_d     (instr_d),
      .pc_plus_4_d (pc_plus_4_d),
      .exp_pc      (m_pc),
      .exp_valid_d (m_valid_d),
      .exp_instr_d (m_instr_d),
      .exp_pc4_d   (m_pc4_d),
      .exp_err     (exp_err),
      .exp_prdata  (exp_prdata),
      .errors      (chk_errors),
      .checks      (checks),
      .beats       (beats)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;   // 40 ns period
   end

   task automatic apb_access(logic wr, apb_addr_t addr, word_t data);
      int cyc;
      cyc = 0;
      @(posedge clk);
      psel    <= 1'b1;   // setup phase
      penable <= 1'b0;
      pwrite  <= wr;
      paddr   <= addr;
      pwdata  <= data;
      @(posedge clk);
      penable <= 1'b1;   // access phase
      @(posedge clk);
      while (pready !== 1'b1 && cyc < 16) begin
         @(posedge clk);
         cyc++;
      end
      if (pready !== 1'b1) begin
         $display("timeout: APB access to %h never completed", addr);
         tb_fails++;
      end
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic apb_write(apb_addr_t addr, word_t data);
      apb_access(1'b1, addr, data);
   endtask

   task automatic apb_read(apb_addr_t addr);
      apb_access(1'b0, addr, '0);   // data checked by the checker
   endtask

   task automatic wait_beats(int n, int limit);
      int target;
      int cyc;
      target = beats + n;
      cyc    = 0;
      while (beats < target && cyc < limit) begin
         @(posedge clk);
         cyc++;
      end
      if (beats < target) begin
         $display("timeout: fewer than %0d decode beats in %0d cycles", n, limit);
         tb_fails++;
      end
   endtask

   task automatic wait_valid_low(int limit);
      int cyc;
      cyc = 0;
      while (valid_d !== 1'b0 && cyc < limit) begin
         @(posedge clk);
         cyc++;
      end
      if (valid_d !== 1'b0) begin
         $display("timeout: valid_d still high %0d cycles after run was cleared", limit);
         tb_fails++;
      end
   endtask

   task automatic redirect_to(word_t target);
      @(posedge clk);
      branch      <= 1'b1;
      branch_addr <= target;
      @(posedge clk);
      branch <= 1'b0;
   endtask

   task automatic finish_test(string name);
      int errs;
      @(negedge clk);   // compares of the last edge are counted by now
      errs      = chk_errors + tb_fails - test_base;
      test_base = chk_errors + tb_fails;
      if (errs != 0)
         n_failed++;
      $display("test %s: %s, %0d errors", name, (errs == 0) ? "ok" : "failed", errs);
   endtask

   initial begin
      int unsigned seed;
      int unsigned r;
      seed = 58;
      r    = $urandom(seed);
      arst_n        = 1'b0;
      psel          = 1'b0;
      penable       = 1'b0;
      pwrite        = 1'b0;
      paddr         = '0;
      pwdata        = '0;
      jump          = 1'b0;
      jump_reg      = 1'b0;
      branch        = 1'b0;
      jump_addr     = RESET_PC;
      jump_reg_addr = RESET_PC;
      branch_addr   = RESET_PC;
      enable        = 1'b1;
      repeat (8) @(posedge clk);
      arst_n <= 1'b1;

      repeat (2) @(posedge clk);
      apb_read(REG_CTRL);
      finish_test("reset state");

      for (int n = 0; n < 64; n++)
         apb_write(IMEM_BASE + apb_addr_t'(WORD_BYTES * n), program_word(n));
      apb_write(REG_CTRL, 32'h1);
      wait_beats(40, 100);
      apb_read(REG_PC);
      finish_test("program load and sequential fetch");

      repeat (24) begin
         @(posedge clk);
         r = $urandom;
         branch        <= r[0];   // any mix lets the priority decide
         jump          <= r[1];
         jump_reg      <= r[2];
         branch_addr   <= rand_target();
         jump_addr     <= rand_target();
         jump_reg_addr <= rand_target();
         @(posedge clk);
         branch   <= 1'b0;
         jump     <= 1'b0;
         jump_reg <= 1'b0;
         wait_beats(1 + $urandom % 5, 20);
      end
      finish_test("redirects");

      redirect_to(RESET_PC);
      repeat (8) begin
         @(posedge clk);
         enable <= 1'b0;
         repeat (1 + $urandom % 4) @(posedge clk);
         enable <= 1'b1;
         repeat (1 + $urandom % 4) @(posedge clk);
      end
      wait_beats(4, 20);
      finish_test("stall");

      redirect_to(RESET_PC);
      apb_write(IMEM_BASE + 16'h8, 32'hdead_beef);   // locked while running
      apb_write(REG_PC, 32'h0);
      apb_read(IMEM_BASE);
      apb_read(16'h0800);                             // unmapped
      redirect_to(RESET_PC);                          // fetch the program again
      wait_beats(16, 40);
      finish_test("bus errors");

      apb_write(REG_CTRL, 32'h0);
      wait_valid_low(3);
      repeat (6) @(posedge clk);   // PC must stay frozen
      apb_read(REG_CTRL);
      finish_test("stop");

      $display("tests 6, failed %0d, checks %0d, errors %0d",
               n_failed, checks, chk_errors + tb_fails);
      if (n_failed == 0 && chk_errors + tb_fails == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule
